// File: common/sparse_chunk_defs.svh
`ifndef SPARSE_CHUNK_DEFS_SVH
`define SPARSE_CHUNK_DEFS_SVH

////////////////////////////////////////////////////////////
// Chunk geometry
////////////////////////////////////////////////////////////

// Bytes and sparsemap bits per write beat
`define CHUNK_BUS_SIZE 4

// Channel positions in one chunk
`define CHUNK_MEM_SIZE 32

// Sparsemap bits per read word, also the prefix sum width
`define CHUNK_PS_SIZE 8

// Ping-pong chunk buffers
`define CHUNK_BANKS 2

// Derived counts
`define CHUNK_BEATS (`CHUNK_MEM_SIZE / `CHUNK_BUS_SIZE)
`define CHUNK_MAP_WORDS (`CHUNK_MEM_SIZE / `CHUNK_PS_SIZE)

`endif

// File: common/sparse_chunk_pkg.sv
`default_nettype none

`include "sparse_chunk_defs.svh"

package sparse_chunk_pkg;

	// One activation byte
	typedef logic [7:0] data_byte_t;

	// One sparsemap read word
	typedef logic [`CHUNK_PS_SIZE-1:0] sparsemap_word_t;

	// Bit position inside a sparsemap word
	typedef logic [$clog2(`CHUNK_PS_SIZE)-1:0] ps_index_t;

	// Holds CHUNK_MEM_SIZE itself, one bit wider than an index
	typedef logic [$clog2(`CHUNK_MEM_SIZE):0] data_addr_t;

	// Set bits in one word, 0 up to CHUNK_PS_SIZE
	typedef logic [$clog2(`CHUNK_PS_SIZE):0] bit_count_t;

	typedef logic [$clog2(`CHUNK_BEATS)-1:0] beat_count_t;
	typedef logic [$clog2(`CHUNK_MAP_WORDS)-1:0] map_addr_t;
	typedef logic [$clog2(`CHUNK_BANKS)-1:0] bank_t;

	// Write side FSM
	typedef enum logic {
		WR_IDLE,
		WR_FILL
	} wr_state_e;

	// Base register update
	typedef enum logic [1:0] {
		ADDR_HOLD,
		ADDR_CLEAR,
		ADDR_ADVANCE
	} addr_op_e;

endpackage

`default_nettype wire

// File: design/prefix_sum.sv
`default_nettype none

`include "sparse_chunk_defs.svh"

module prefix_sum (
	input  wire sparse_chunk_pkg::sparsemap_word_t word_i,
	output sparse_chunk_pkg::bit_count_t count_o [`CHUNK_PS_SIZE],
	output sparse_chunk_pkg::bit_count_t total_o
);

	// Running count, entry k covers bits 0 .. k-1
	sparse_chunk_pkg::bit_count_t chain_w [`CHUNK_PS_SIZE+1];

	assign chain_w[0] = '0;

	////////////////////////////////////////////////////////////
	// Adder chain
	////////////////////////////////////////////////////////////

	for (genvar k = 0; k < `CHUNK_PS_SIZE; k++) begin : g_chain
		assign chain_w[k+1] = chain_w[k] + sparse_chunk_pkg::bit_count_t'(word_i[k]);

		// Exclusive count seen by position k
		assign count_o[k] = chain_w[k];
	end

	// Whole word popcount, used to advance the base
	assign total_o = chain_w[`CHUNK_PS_SIZE];

endmodule

`default_nettype wire

// File: chunk_buffer/chunk_buffer.sv
`default_nettype none

`include "sparse_chunk_defs.svh"

module chunk_buffer (
	input  wire                                   clk_i,
	input  wire                                   rst_i,

	// Write side, one beat at a time
	input  wire                                   wr_en_i,
	input  wire sparse_chunk_pkg::beat_count_t    wr_count_i,
	input  wire [`CHUNK_BUS_SIZE-1:0]             wr_sparsemap_i,
	input  wire sparse_chunk_pkg::data_byte_t [`CHUNK_BUS_SIZE-1:0] wr_nonzero_data_i,

	// Read side
	input  wire sparse_chunk_pkg::map_addr_t      rd_sparsemap_addr_i,
	input  wire sparse_chunk_pkg::data_addr_t     rd_data_addr_i,
	output sparse_chunk_pkg::sparsemap_word_t     rd_sparsemap_o,
	output sparse_chunk_pkg::data_byte_t          rd_data_o
);

	localparam int IDX_W = $clog2(`CHUNK_MEM_SIZE);

	// One bit per channel position
	logic [`CHUNK_MEM_SIZE-1:0] map_r;

	// Nonzero bytes, packed from position zero
	sparse_chunk_pkg::data_byte_t data_r [`CHUNK_MEM_SIZE];

	logic [IDX_W-1:0] beat_base_w;
	logic [IDX_W-1:0] data_idx_w;
	logic data_in_range_w;

	////////////////////////////////////////////////////////////
	// Beat writes
	////////////////////////////////////////////////////////////

	// Beat k lands at position k * CHUNK_BUS_SIZE
	assign beat_base_w = IDX_W'(wr_count_i) * IDX_W'(`CHUNK_BUS_SIZE);

	always_ff @(posedge clk_i) begin
		if (wr_en_i) begin
			for (int i = 0; i < `CHUNK_BUS_SIZE; i++) begin
				map_r[beat_base_w + IDX_W'(i)]  <= wr_sparsemap_i[i];
				data_r[beat_base_w + IDX_W'(i)] <= wr_nonzero_data_i[i];
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Registered reads
	////////////////////////////////////////////////////////////

	// Address may equal CHUNK_MEM_SIZE when every bit is set
	assign data_in_range_w = (rd_data_addr_i < sparse_chunk_pkg::data_addr_t'(`CHUNK_MEM_SIZE));
	assign data_idx_w      = rd_data_addr_i[IDX_W-1:0];

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			rd_sparsemap_o <= '0;
		end
		else begin
			rd_sparsemap_o <= map_r[rd_sparsemap_addr_i * `CHUNK_PS_SIZE +: `CHUNK_PS_SIZE];
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			rd_data_o <= '0;
		end
		else if (data_in_range_w) begin
			rd_data_o <= data_r[data_idx_w];
		end
		else begin
			rd_data_o <= '0;
		end
	end

endmodule

`default_nettype wire

// File: design/chunk_write_ctrl.sv
`default_nettype none

`include "sparse_chunk_defs.svh"

module chunk_write_ctrl (
	input  wire                                clk_i,
	input  wire                                rst_i,
	input  wire                                wr_valid_i,
	input  wire                                wr_last_i,
	input  wire                                wr_sel_i,
	output logic [`CHUNK_BANKS-1:0]            wr_en_o,
	output sparse_chunk_pkg::beat_count_t      wr_count_o
);

	localparam sparse_chunk_pkg::beat_count_t LAST_BEAT =
		sparse_chunk_pkg::beat_count_t'(`CHUNK_BEATS - 1);

	sparse_chunk_pkg::wr_state_e   state_r;
	sparse_chunk_pkg::bank_t       bank_r;
	sparse_chunk_pkg::beat_count_t count_r;
	// Chunk capacity reached, later beats are dropped
	logic full_r;

	sparse_chunk_pkg::bank_t       cur_bank_w;

	// First beat takes the bank straight from wr_sel_i
	assign cur_bank_w = (state_r == sparse_chunk_pkg::WR_IDLE) ?
		sparse_chunk_pkg::bank_t'(wr_sel_i) : bank_r;

	always_comb begin
		wr_en_o = '0;
		if (wr_valid_i && !full_r) begin
			wr_en_o[cur_bank_w] = 1'b1;
		end
	end

	assign wr_count_o = count_r;

	////////////////////////////////////////////////////////////
	// Chunk FSM and beat counter
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_r <= sparse_chunk_pkg::WR_IDLE;
			bank_r  <= '0;
			count_r <= '0;
			full_r  <= 1'b0;
		end
		else if (wr_valid_i) begin
			if (wr_last_i) begin
				state_r <= sparse_chunk_pkg::WR_IDLE;
				count_r <= '0;
				full_r  <= 1'b0;
			end
			else begin
				if (state_r == sparse_chunk_pkg::WR_IDLE) begin
					state_r <= sparse_chunk_pkg::WR_FILL;
					bank_r  <= cur_bank_w;
				end
				// Hold the count at the last beat once full
				if (!full_r) begin
					if (count_r == LAST_BEAT) begin
						full_r <= 1'b1;
					end
					else begin
						count_r <= count_r + 1'b1;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: design/chunk_read_ctrl.sv
`default_nettype none

`include "sparse_chunk_defs.svh"

module chunk_read_ctrl (
	input  wire                                    clk_i,
	input  wire                                    rst_i,
	input  wire sparse_chunk_pkg::bank_t           rd_sel_i,
	input  wire sparse_chunk_pkg::ps_index_t       pri_enc_match_addr_i,
	input  wire                                    pri_enc_end_i,
	input  wire                                    chunk_start_i,

	// Registered outputs of every bank
	input  wire sparse_chunk_pkg::sparsemap_word_t bank_sparsemap_i [`CHUNK_BANKS],
	input  wire sparse_chunk_pkg::data_byte_t      bank_data_i [`CHUNK_BANKS],

	output sparse_chunk_pkg::sparsemap_word_t      rd_sparsemap_o,
	output sparse_chunk_pkg::data_byte_t           rd_data_o,
	output sparse_chunk_pkg::data_addr_t           rd_data_addr_o
);

	sparse_chunk_pkg::bit_count_t prefix_count_w [`CHUNK_PS_SIZE];
	sparse_chunk_pkg::bit_count_t word_total_w;

	sparse_chunk_pkg::addr_op_e   addr_op_w;
	// Data entry of the first set bit in the current word
	sparse_chunk_pkg::data_addr_t base_addr_r;
	sparse_chunk_pkg::data_addr_t base_eff_w;

	////////////////////////////////////////////////////////////
	// Bank select
	////////////////////////////////////////////////////////////

	assign rd_sparsemap_o = bank_sparsemap_i[rd_sel_i];
	assign rd_data_o      = bank_data_i[rd_sel_i];

	prefix_sum u_prefix_sum (
		.word_i  (rd_sparsemap_o),
		.count_o (prefix_count_w),
		.total_o (word_total_w)
	);

	////////////////////////////////////////////////////////////
	// Base register
	////////////////////////////////////////////////////////////

	// End of word wins over chunk start
	always_comb begin
		if (pri_enc_end_i) begin
			addr_op_w = sparse_chunk_pkg::ADDR_ADVANCE;
		end
		else if (chunk_start_i) begin
			addr_op_w = sparse_chunk_pkg::ADDR_CLEAR;
		end
		else begin
			addr_op_w = sparse_chunk_pkg::ADDR_HOLD;
		end
	end

	// A new chunk starts from entry zero in the same cycle
	assign base_eff_w = chunk_start_i ? '0 : base_addr_r;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			base_addr_r <= '0;
		end
		else begin
			case (addr_op_w)
				sparse_chunk_pkg::ADDR_CLEAR: begin
					base_addr_r <= '0;
				end
				sparse_chunk_pkg::ADDR_ADVANCE: begin
					base_addr_r <= base_eff_w +
						sparse_chunk_pkg::data_addr_t'(word_total_w);
				end
				default: begin
					base_addr_r <= base_addr_r;
				end
			endcase
		end
	end

	// Base plus the set bits below the matched position
	assign rd_data_addr_o = base_eff_w +
		sparse_chunk_pkg::data_addr_t'(prefix_count_w[pri_enc_match_addr_i]);

endmodule

`default_nettype wire

// File: design/sparse_chunk_top.sv
`default_nettype none

`include "sparse_chunk_defs.svh"

module sparse_chunk_top (
	input  wire                                   clk_i,
	input  wire                                   rst_i,

	// Compressed chunk stream
	input  wire                                   wr_valid_i,
	input  wire                                   wr_last_i,
	input  wire                                   wr_sel_i,
	input  wire [`CHUNK_BUS_SIZE-1:0]             wr_sparsemap_i,
	input  wire sparse_chunk_pkg::data_byte_t [`CHUNK_BUS_SIZE-1:0] wr_nonzero_data_i,

	// Read side and priority encoder results
	input  wire sparse_chunk_pkg::bank_t          rd_sel_i,
	input  wire sparse_chunk_pkg::map_addr_t      rd_sparsemap_addr_i,
	input  wire sparse_chunk_pkg::ps_index_t      pri_enc_match_addr_i,
	input  wire                                   pri_enc_end_i,
	input  wire                                   chunk_start_i,

	output sparse_chunk_pkg::sparsemap_word_t     rd_sparsemap_o,
	output sparse_chunk_pkg::data_byte_t          rd_data_o
);

	logic [`CHUNK_BANKS-1:0]           wr_en_w;
	sparse_chunk_pkg::beat_count_t     wr_count_w;
	sparse_chunk_pkg::data_addr_t      rd_data_addr_w;

	sparse_chunk_pkg::sparsemap_word_t bank_sparsemap_w [`CHUNK_BANKS];
	sparse_chunk_pkg::data_byte_t      bank_data_w [`CHUNK_BANKS];

	chunk_write_ctrl u_chunk_write_ctrl (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.wr_valid_i (wr_valid_i),
		.wr_last_i  (wr_last_i),
		.wr_sel_i   (wr_sel_i),
		.wr_en_o    (wr_en_w),
		.wr_count_o (wr_count_w)
	);

	////////////////////////////////////////////////////////////
	// Ping-pong chunk buffers
	////////////////////////////////////////////////////////////

	for (genvar b = 0; b < `CHUNK_BANKS; b++) begin : g_bank
		chunk_buffer u_chunk_buffer (
			.clk_i               (clk_i),
			.rst_i               (rst_i),
			.wr_en_i             (wr_en_w[b]),
			.wr_count_i          (wr_count_w),
			.wr_sparsemap_i      (wr_sparsemap_i),
			.wr_nonzero_data_i   (wr_nonzero_data_i),
			.rd_sparsemap_addr_i (rd_sparsemap_addr_i),
			.rd_data_addr_i      (rd_data_addr_w),
			.rd_sparsemap_o      (bank_sparsemap_w[b]),
			.rd_data_o           (bank_data_w[b])
		);
	end

	chunk_read_ctrl u_chunk_read_ctrl (
		.clk_i                (clk_i),
		.rst_i                (rst_i),
		.rd_sel_i             (rd_sel_i),
		.pri_enc_match_addr_i (pri_enc_match_addr_i),
		.pri_enc_end_i        (pri_enc_end_i),
		.chunk_start_i        (chunk_start_i),
		.bank_sparsemap_i     (bank_sparsemap_w),
		.bank_data_i          (bank_data_w),
		.rd_sparsemap_o       (rd_sparsemap_o),
		.rd_data_o            (rd_data_o),
		.rd_data_addr_o       (rd_data_addr_w)
	);

endmodule

`default_nettype wire

// File: test/sparse_chunk_assertions.sv
`default_nettype none

`include "sparse_chunk_defs.svh"

module sparse_chunk_assertions (
	input wire                                    clk_i,
	input wire                                    rst_i,
	input wire                                    wr_last_i,
	input wire [`CHUNK_BANKS-1:0]                 wr_en_i,
	input wire sparse_chunk_pkg::beat_count_t     wr_count_i,
	input wire sparse_chunk_pkg::wr_state_e       wr_state_i,
	input wire sparse_chunk_pkg::data_addr_t      base_addr_i,
	input wire sparse_chunk_pkg::sparsemap_word_t rd_sparsemap_i,
	input wire sparse_chunk_pkg::data_byte_t      rd_data_i
);

	localparam sparse_chunk_pkg::beat_count_t LAST_BEAT =
		sparse_chunk_pkg::beat_count_t'(`CHUNK_BEATS - 1);

	////////////////////////////////////////////////////////////
	// Write side
	////////////////////////////////////////////////////////////

	// A chunk keeps its bank until the last beat
	a_wr_en_bank: assert property (@(posedge clk_i) disable iff (rst_i)
		((|wr_en_i) && !wr_last_i) |=>
			((wr_en_i == '0) || (wr_en_i == $past(wr_en_i))))
		else $error("wr_en moved to another bank within a chunk");

	// Beats past the chunk's capacity are masked and the count holds
	a_wr_capacity: assert property (@(posedge clk_i) disable iff (rst_i)
		((|wr_en_i) && !wr_last_i && (wr_count_i == LAST_BEAT)) |=>
			((wr_en_i == '0) && (wr_count_i == LAST_BEAT)))
		else $error("beat written past chunk capacity");

	////////////////////////////////////////////////////////////
	// Read side
	////////////////////////////////////////////////////////////

	// Base counts nonzero entries, never more than a chunk
	a_base_range: assert property (@(posedge clk_i) disable iff (rst_i)
		base_addr_i <= sparse_chunk_pkg::data_addr_t'(`CHUNK_MEM_SIZE))
		else $error("base address exceeds chunk size");

	// Known reset values on the first cycle out of reset
	a_reset_values: assert property (@(posedge clk_i)
		$fell(rst_i) |-> (rd_sparsemap_i == '0) && (rd_data_i == '0) &&
			(base_addr_i == '0) && (wr_state_i == sparse_chunk_pkg::WR_IDLE))
		else $error("read outputs or state not cleared by reset");

endmodule

bind sparse_chunk_top sparse_chunk_assertions u_sparse_chunk_assertions (
	.clk_i          (clk_i),
	.rst_i          (rst_i),
	.wr_last_i      (wr_last_i),
	.wr_en_i        (wr_en_w),
	.wr_count_i     (wr_count_w),
	.wr_state_i     (u_chunk_write_ctrl.state_r),
	.base_addr_i    (u_chunk_read_ctrl.base_addr_r),
	.rd_sparsemap_i (rd_sparsemap_o),
	.rd_data_i      (rd_data_o)
);

`default_nettype wire

// File: test/sparse_chunk_tb.sv
`default_nettype none

`include "sparse_chunk_defs.svh"

module sparse_chunk_tb;

	localparam int PERIOD     = 20;
	localparam int BUS        = `CHUNK_BUS_SIZE;
	localparam int MEM        = `CHUNK_MEM_SIZE;
	localparam int PS         = `CHUNK_PS_SIZE;
	localparam int BEATS      = `CHUNK_BEATS;
	localparam int MAP_WORDS  = `CHUNK_MAP_WORDS;
	localparam int NUM_CHUNKS = 8;
	localparam int MAX_EXTRA  = 3;

	// Every write or read pass is bounded by one chunk's worth of cycles
	localparam int OP_CYCLES       = BEATS + MAX_EXTRA + MAP_WORDS * (PS + 1);
	localparam int WATCHDOG_CYCLES = (2 * NUM_CHUNKS + 10) * OP_CYCLES + 50;

	logic clk_i;
	logic rst_i;
	logic wr_valid_i;
	logic wr_last_i;
	logic wr_sel_i;
	logic [BUS-1:0] wr_sparsemap_i;
	sparse_chunk_pkg::data_byte_t [BUS-1:0] wr_nonzero_data_i;
	sparse_chunk_pkg::bank_t rd_sel_i;
	sparse_chunk_pkg::map_addr_t rd_sparsemap_addr_i;
	sparse_chunk_pkg::ps_index_t pri_enc_match_addr_i;
	logic pri_enc_end_i;
	logic chunk_start_i;
	sparse_chunk_pkg::sparsemap_word_t rd_sparsemap_o;
	sparse_chunk_pkg::data_byte_t rd_data_o;

	int seed;

	// Reference model, one chunk per bank
	logic [MEM-1:0] model_map [`CHUNK_BANKS];
	sparse_chunk_pkg::data_byte_t model_data [`CHUNK_BANKS][MEM];

	sparse_chunk_top dut0 (
		.clk_i                (clk_i),
		.rst_i                (rst_i),
		.wr_valid_i           (wr_valid_i),
		.wr_last_i            (wr_last_i),
		.wr_sel_i             (wr_sel_i),
		.wr_sparsemap_i       (wr_sparsemap_i),
		.wr_nonzero_data_i    (wr_nonzero_data_i),
		.rd_sel_i             (rd_sel_i),
		.rd_sparsemap_addr_i  (rd_sparsemap_addr_i),
		.pri_enc_match_addr_i (pri_enc_match_addr_i),
		.pri_enc_end_i        (pri_enc_end_i),
		.chunk_start_i        (chunk_start_i),
		.rd_sparsemap_o       (rd_sparsemap_o),
		.rd_data_o            (rd_data_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #(PERIOD / 2) clk_i = ~clk_i;
	end

	initial begin
		#(WATCHDOG_CYCLES * PERIOD);
		$display("Watchdog expired before the test sequence finished");
		$display("Simulation failed");
		$fatal(1, "timeout");
	end

	////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////

	task automatic check_sparsemap(input sparse_chunk_pkg::sparsemap_word_t actual,
		input sparse_chunk_pkg::sparsemap_word_t expected, input int bank, input int word);
		if (actual !== expected) begin
			$display("FAIL rd_sparsemap_o bank %0d word %0d: got 0x%h, expected 0x%h",
				bank, word, actual, expected);
			$display("Simulation failed");
			$fatal(1, "sparsemap readback mismatch");
		end
	endtask

	task automatic check_data(input sparse_chunk_pkg::data_byte_t actual,
		input sparse_chunk_pkg::data_byte_t expected, input int bank, input int entry);
		if (actual !== expected) begin
			$display("FAIL rd_data_o bank %0d entry %0d: got 0x%h, expected 0x%h",
				bank, entry, actual, expected);
			$display("Simulation failed");
			$fatal(1, "gathered byte mismatch");
		end
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	// Random chunk into the model, then streamed beat by beat
	task automatic write_chunk(input int bank, input int dens, input int extra,
		input bit flip_sel);
		int i;
		int k;
		int r;
		int nz;
		nz = 0;
		for (i = 0; i < MEM; i++) begin
			r = $random(seed) & 3;
			model_map[bank][i] = (r < dens);
			if (r < dens) begin
				nz++;
			end
		end
		// Nonzero bytes first, random padding after them
		for (i = 0; i < MEM; i++) begin
			r = $random(seed);
			model_data[bank][i] = sparse_chunk_pkg::data_byte_t'(r);
			if (i < nz && model_data[bank][i] == 8'h00) begin
				model_data[bank][i] = 8'ha5;
			end
		end
		for (k = 0; k < BEATS + extra; k++) begin
			wr_valid_i = 1'b1;
			wr_last_i  = (k == BEATS + extra - 1);
			if (k == 0) begin
				wr_sel_i = (bank != 0);
			end
			else if (flip_sel) begin
				wr_sel_i = (bank == 0);
			end
			if (k < BEATS) begin
				wr_sparsemap_i = model_map[bank][k*BUS +: BUS];
				for (i = 0; i < BUS; i++) begin
					wr_nonzero_data_i[i] = model_data[bank][k*BUS + i];
				end
			end
			else begin
				// Overflow beats carry garbage that must be dropped
				wr_sparsemap_i = BUS'($random(seed));
				for (i = 0; i < BUS; i++) begin
					wr_nonzero_data_i[i] = sparse_chunk_pkg::data_byte_t'($random(seed));
				end
			end
			@(posedge clk_i);
			#2;
		end
		wr_valid_i = 1'b0;
		wr_last_i  = 1'b0;
	endtask

	// Walks every word like the priority encoder would
	task automatic read_chunk(input int bank);
		sparse_chunk_pkg::sparsemap_word_t exp_word;
		int base;
		int cnt;
		int last;
		int w;
		int p;
		bit first;
		base  = 0;
		first = 1'b1;
		rd_sel_i = sparse_chunk_pkg::bank_t'(bank);
		for (w = 0; w < MAP_WORDS; w++) begin
			exp_word = model_map[bank][w*PS +: PS];
			rd_sparsemap_addr_i = sparse_chunk_pkg::map_addr_t'(w);
			@(posedge clk_i);
			#2;
			check_sparsemap(rd_sparsemap_o, exp_word, bank, w);
			last = -1;
			for (p = 0; p < PS; p++) begin
				if (exp_word[p]) begin
					last = p;
				end
			end
			cnt = 0;
			if (last < 0) begin
				// Empty word, end of word only
				pri_enc_match_addr_i = '0;
				pri_enc_end_i = 1'b1;
				chunk_start_i = first;
				first = 1'b0;
				@(posedge clk_i);
				#2;
				pri_enc_end_i = 1'b0;
				chunk_start_i = 1'b0;
			end
			else begin
				for (p = 0; p <= last; p++) begin
					if (exp_word[p]) begin
						pri_enc_match_addr_i = sparse_chunk_pkg::ps_index_t'(p);
						pri_enc_end_i = (p == last);
						chunk_start_i = first;
						first = 1'b0;
						@(posedge clk_i);
						#2;
						pri_enc_end_i = 1'b0;
						chunk_start_i = 1'b0;
						check_data(rd_data_o, model_data[bank][base + cnt], bank, base + cnt);
						cnt++;
					end
				end
			end
			base = base + cnt;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin
		int c;
		seed = 32'hdbea_5bd1;
		rst_i = 1'b1;
		wr_valid_i = 1'b0;
		wr_last_i = 1'b0;
		wr_sel_i = 1'b0;
		wr_sparsemap_i = '0;
		wr_nonzero_data_i = '0;
		rd_sel_i = '0;
		rd_sparsemap_addr_i = '0;
		pri_enc_match_addr_i = '0;
		pri_enc_end_i = 1'b0;
		chunk_start_i = 1'b0;
		repeat (4) @(posedge clk_i);
		#2;
		rst_i = 1'b0;

		write_chunk(0, 2, 0, 1'b0);
		read_chunk(0);

		// Fill one bank while the other one drains
		for (c = 0; c < NUM_CHUNKS; c++) begin
			fork
				write_chunk((c + 1) % 2, c % 3 + 1, 0, 1'b0);
				read_chunk(c % 2);
			join
		end
		read_chunk(NUM_CHUNKS % 2);

		// Overflow beats and wr_sel_i changing mid chunk
		write_chunk(0, 2, MAX_EXTRA, 1'b1);
		read_chunk(0);
		read_chunk(1);
		write_chunk(1, 3, 2, 1'b1);
		read_chunk(1);
		read_chunk(0);

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
+incdir+common
common/sparse_chunk_pkg.sv
design/prefix_sum.sv
chunk_buffer/chunk_buffer.sv
design/chunk_write_ctrl.sv
design/chunk_read_ctrl.sv
design/sparse_chunk_top.sv
test/sparse_chunk_assertions.sv
test/sparse_chunk_tb.sv

// File: Makefile
# Verilator simulation of the sparse chunk buffer

VERILATOR ?= verilator
TOP       ?= sparse_chunk_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
